/* vlog.f */
+incdir+verilog
verilog/render_pkg.sv
verilog/cfg_if.sv
verilog/pixel_if.sv
verilog/apb_render_regs.sv
verilog/pixel_addr.sv
verilog/tile_color.sv
verilog/tile_renderer.sv
verification/tb_tile_renderer.sv

/* run.sh */
#!/bin/sh
# compile and run the tile renderer testbench with verilator

rm -rf obj_dir build.log sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_tile_renderer \
  -f vlog.f > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_tile_renderer > sim.log 2>&1

grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

/* verification/tb_tile_renderer.sv */
`default_nettype none

`include "render_config.svh"

module tb_tile_renderer
  import render_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYC     = 4;
  localparam int APB_RAND    = 32;
  localparam int UNMAPPED    = 8;
  localparam int ADDR_PIX    = 300;
  localparam int FLAT_PIX    = 300;
  localparam int EXPL_TRIALS = 40;
  localparam int APB_OPS     = 4 + 2 * APB_RAND + UNMAPPED + 4 + 2 * EXPL_TRIALS;
  localparam int PIX_OPS     = ADDR_PIX + FLAT_PIX + 22 * EXPL_TRIALS;
  localparam int MAX_CYC     = RST_CYC + 1 + 2 * APB_OPS + PIX_OPS;  // apb access is 2 cycles

  logic        clk = 1'b0;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  xcoord_t     draw_x;
  ycoord_t     draw_y;
  logic [1:0]  tile_state = 2'd0;
  map_addr_t   map_addr;
  rgb_t        rgb;

  // reference copy of the register file and the map
  logic       m_en [2];
  logic [3:0] m_row [2];
  logic [4:0] m_col [2];
  rgb_t       m_bg;
  rgb_t       m_border;
  logic [1:0] map_mem [0:255];

  tile_renderer tile_renderer_i (
    .clk (clk), .i_rst_n (rst_n),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata),
    .o_prdata (prdata), .o_pready (pready), .o_pslverr (pslverr),
    .i_draw_x (draw_x), .i_draw_y (draw_y), .i_tile_state (tile_state),
    .o_map_addr (map_addr), .o_rgb (rgb)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) tile_state <= map_mem[map_addr];  // synchronous map memory

  initial begin
    #(MAX_CYC * CLK_PERIOD + 100 * CLK_PERIOD);
    $display("Some tests failed");
    $fatal(1, "watchdog timeout, the tests did not finish in time");
  end

  // ------------------------------
  // checks and reference model
  // ------------------------------
  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERROR %s expected %0h actual %0h", name, exp_v, act_v);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic outside_map(input int x, input int y);
    return (x < `BORDER_SIDE) || (x >= `SCREEN_W - `BORDER_SIDE) ||
           (y < `BORDER_TOP) || (y >= `SCREEN_H - `BORDER_BOT);
  endfunction

  function automatic int expected_addr(input int x, input int y);
    if (outside_map(x, y)) return 0;
    return ((y - `BORDER_TOP) >> `BLK_LOG2) * `NUM_COL + ((x - `BORDER_SIDE) >> `BLK_LOG2);
  endfunction

  function automatic rgb_t expected_rgb(input int x, input int y, input logic [1:0] st);
    int   r;
    int   c;
    int   dr;
    int   dc;
    logic hit;
    if (outside_map(x, y)) return m_border;
    r   = (y - `BORDER_TOP) >> `BLK_LOG2;
    c   = (x - `BORDER_SIDE) >> `BLK_LOG2;
    hit = 1'b0;
    for (int k = 0; k < 2; k++) begin
      dr = r - int'(m_row[k]);
      dc = c - int'(m_col[k]);
      if (m_en[k] && ((dr == 0 && dc >= -1 && dc <= 1) || (dc == 0 && (dr == 1 || dr == -1))))
        hit = 1'b1;
    end
    if (st == 2'd1) return `COLOR_PERM;
    if (st == 2'd3) return `COLOR_BOMB;
    if (hit) return `COLOR_EXPL;
    return (st == 2'd2) ? `COLOR_DEST : m_bg;
  endfunction

  function automatic logic [31:0] reg_value(input int idx);
    if (idx < 2) return (32'(m_en[idx]) << 16) | (32'(m_row[idx]) << 8) | 32'(m_col[idx]);
    return (idx == 2) ? 32'(m_bg) : 32'(m_border);
  endfunction

  // ------------------------------
  // bus and pixel drivers
  // ------------------------------
  // starts and ends on a falling edge
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;                    // access phase
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    check_value("apb pready", 32'd1, 32'(pready));
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input int idx, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, 4'(idx * 4), data, rd, err);
    check_value("apb write pslverr", 32'd0, 32'(err));
    if (idx < 2) begin
      m_en[idx]  = data[16];
      m_row[idx] = data[11:8];
      m_col[idx] = data[4:0];
    end else if (idx == 2) m_bg = data[11:0];
    else m_border = data[11:0];
  endtask

  task automatic reg_read_check(input int idx, input string name);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, 4'(idx * 4), 32'd0, rd, err);
    check_value({name, " pslverr"}, 32'd0, 32'(err));
    check_value(name, reg_value(idx), rd);
  endtask

  task automatic draw_pixel(input int x, input int y, input string name);
    int exp_addr;
    draw_x   = xcoord_t'(x);
    draw_y   = ycoord_t'(y);
    exp_addr = expected_addr(x, y);
    @(posedge clk);
    check_value({name, " map addr"}, 32'(exp_addr), 32'(map_addr));
    @(negedge clk);
    check_value({name, " rgb"}, 32'(expected_rgb(x, y, map_mem[exp_addr])), 32'(rgb));
  endtask

  task automatic draw_tile(input int tr, input int tc, input string name);
    draw_pixel(`BORDER_SIDE + tc * 64 + int'($urandom % 64),
               `BORDER_TOP + tr * 64 + int'($urandom % 64), name);
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    int          a;
    int          tr;
    int          tc;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    // inside the map, so only the stage reset gives the border colour
    draw_x = xcoord_t'(100);
    draw_y = ycoord_t'(200);
    rst_n  = 1'b0;
    m_en   = '{1'b0, 1'b0};
    m_row  = '{4'd0, 4'd0};
    m_col  = '{5'd0, 5'd0};
    m_bg     = `BG_RESET;
    m_border = `BORDER_RESET;
    void'($urandom(32'hf7d4));
    for (a = 0; a < 256; a++) map_mem[a] = 2'($urandom % 4);
    repeat (RST_CYC) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // 1. reset values
    check_value("reset rgb", 32'(`BORDER_RESET), 32'(rgb));
    for (a = 0; a < 4; a++) reg_read_check(a, "reset readback");

    // 2. random register traffic and unmapped addresses
    for (a = 0; a < APB_RAND; a++) begin
      tr = int'($urandom % 4);
      reg_write(tr, $urandom);
      reg_read_check(tr, "apb readback");
    end
    for (a = 0; a < UNMAPPED; a++) begin
      apb_access(1'($urandom % 2), 4'(4 * ($urandom % 4) + 1 + $urandom % 3), $urandom, rd, err);
      check_value("unmapped pslverr", 32'd1, 32'(err));
    end

    // 3. map address and border, explosions off
    reg_write(0, 32'd0);
    reg_write(1, 32'd0);
    reg_write(3, $urandom);
    for (a = 0; a < ADDR_PIX; a++)
      draw_pixel(int'($urandom % 1400), int'($urandom % 900), "addr and border");

    // 4. flat tile colours
    reg_write(2, $urandom);
    for (a = 0; a < FLAT_PIX; a++)
      draw_tile(int'($urandom % `NUM_ROW), int'($urandom % `NUM_COL), "flat colour");

    // 5. explosion crosses, edge columns included
    for (a = 0; a < EXPL_TRIALS; a++) begin
      for (int k = 0; k < 2; k++) begin
        tc = ($urandom % 3 == 0) ? 0 : ($urandom % 3 == 0) ? 18 : int'($urandom % 19);
        reg_write(k, {15'd0, 1'($urandom % 4 != 0), 4'd0, 4'($urandom % 11), 3'd0, 5'(tc)});
      end
      for (int k = 0; k < 2; k++) begin
        for (int dr = -1; dr <= 1; dr++)
          for (int dc = -1; dc <= 1; dc++) begin
            tr = int'(m_row[k]) + dr;
            tc = int'(m_col[k]) + dc;
            if (tr >= 0 && tr < `NUM_ROW && tc >= 0 && tc < `NUM_COL)
              draw_tile(tr, tc, "explosion cross");
          end
        // neighbours by index, which wrap to the next row
        tr = int'(m_row[k]) * `NUM_COL + int'(m_col[k]);
        if (tr + 1 < `NUM_ROW * `NUM_COL) draw_tile((tr + 1) / 19, (tr + 1) % 19, "no wrap");
        if (tr > 0) draw_tile((tr - 1) / 19, (tr - 1) % 19, "no wrap");
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/tile_renderer.sv */
`default_nettype none

module tile_renderer
  import render_pkg::*;
(
  input  logic        clk,
  input  logic        i_rst_n,
  // apb slave
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [3:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  // pixel stream and map memory
  input  xcoord_t     i_draw_x,
  input  ycoord_t     i_draw_y,
  input  logic [1:0]  i_tile_state,  // one cycle after o_map_addr
  output map_addr_t   o_map_addr,
  output rgb_t        o_rgb
);

  cfg_if   cfg_bus ();
  pixel_if pix_bus ();

  apb_render_regs apb_render_regs_i (
    .clk       (clk),
    .i_rst_n   (i_rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .cfg       (cfg_bus.source)
  );

  pixel_addr pixel_addr_i (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_draw_x   (i_draw_x),
    .i_draw_y   (i_draw_y),
    .o_map_addr (o_map_addr),
    .pix        (pix_bus.source)
  );

  tile_color tile_color_i (
    .i_tile_state (tile_state_e'(i_tile_state)),
    .o_rgb        (o_rgb),
    .pix          (pix_bus.sink),
    .cfg          (cfg_bus.sink)
  );

endmodule

`default_nettype wire

/* verilog/tile_color.sv */
`default_nettype none

`include "render_config.svh"

module tile_color
  import render_pkg::*;
(
  input  tile_state_e i_tile_state,
  output rgb_t        o_rgb,
  pixel_if.sink       pix,
  cfg_if.sink         cfg
);

  // ------------------------------
  // explosion cross test
  // ------------------------------
  // centre plus four neighbours, compared by row and column so that a
  // centre on an edge column never reaches into the next row
  function automatic logic in_cross(input row_t r, input col_t c,
                                    input row_t er, input col_t ec);
    logic [4:0] r_x;
    logic [4:0] er_x;
    logic [5:0] c_x;
    logic [5:0] ec_x;
    logic       same_row;
    logic       same_col;
    r_x  = {1'b0, r};
    er_x = {1'b0, er};
    c_x  = {1'b0, c};
    ec_x = {1'b0, ec};
    same_row = (r == er);
    same_col = (c == ec);
    return (same_row && ((c_x == ec_x) || (c_x == ec_x + 6'd1) || (ec_x == c_x + 6'd1))) ||
           (same_col && ((r_x == er_x + 5'd1) || (er_x == r_x + 5'd1)));
  endfunction

  logic expl0_hit;
  logic expl1_hit;
  logic expl_hit;

  assign expl0_hit = cfg.expl0_en && in_cross(pix.row, pix.col, cfg.expl0_row, cfg.expl0_col);
  assign expl1_hit = cfg.expl1_en && in_cross(pix.row, pix.col, cfg.expl1_row, cfg.expl1_col);
  assign expl_hit  = expl0_hit | expl1_hit;

  // ------------------------------
  // colour mux
  // ------------------------------
  always_comb begin
    if (pix.out_of_map) begin
      o_rgb = cfg.border_rgb;
    end else begin
      case (i_tile_state)
        PERM_BLK: o_rgb = `COLOR_PERM;      // explosions stop at walls
        BOMB:     o_rgb = `COLOR_BOMB;
        DEST_BLK: o_rgb = expl_hit ? `COLOR_EXPL : `COLOR_DEST;
        default:  o_rgb = expl_hit ? `COLOR_EXPL : cfg.bg_rgb;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/pixel_addr.sv */
`default_nettype none

`include "render_config.svh"

module pixel_addr
  import render_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst_n,
  input  xcoord_t   i_draw_x,
  input  ycoord_t   i_draw_y,
  output map_addr_t o_map_addr,
  pixel_if.source   pix
);

  xcoord_t map_x;
  ycoord_t map_y;
  col_t    col;
  row_t    row;
  logic    out_of_map;

  // ------------------------------
  // border region
  // ------------------------------
  always_comb begin
    out_of_map = (i_draw_x < `BORDER_SIDE) ||
                 (i_draw_x >= `SCREEN_W - `BORDER_SIDE) ||
                 (i_draw_y < `BORDER_TOP) ||
                 (i_draw_y >= `SCREEN_H - `BORDER_BOT);
  end

  // position relative to the top left map corner
  assign map_x = i_draw_x - xcoord_t'(`BORDER_SIDE);
  assign map_y = i_draw_y - ycoord_t'(`BORDER_TOP);

  assign col = col_t'(map_x >> `BLK_LOG2);
  assign row = row_t'(map_y >> `BLK_LOG2);

  // row-major tile index, max 10*19+18 = 208
  assign o_map_addr = out_of_map ? '0 :
                      map_addr_t'(row) * map_addr_t'(`NUM_COL) + map_addr_t'(col);

  // ------------------------------
  // pixel stage, lines up with the map memory read
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      pix.out_of_map <= 1'b1;               // border colour until the first pixel
    end else begin
      pix.out_of_map <= out_of_map;
    end
  end

  always_ff @(posedge clk) begin
    pix.row <= row;
    pix.col <= col;
  end

endmodule

`default_nettype wire

/* verilog/apb_render_regs.sv */
`default_nettype none

`include "render_config.svh"

module apb_render_regs (
  input  logic        clk,
  input  logic        i_rst_n,
  input  logic        i_psel,
  input  logic        i_penable,
  input  logic        i_pwrite,
  input  logic [3:0]  i_paddr,
  input  logic [31:0] i_pwdata,
  output logic [31:0] o_prdata,
  output logic        o_pready,
  output logic        o_pslverr,
  cfg_if.source       cfg
);

  logic access;
  logic addr_hit;
  logic wr_en;

  assign access   = i_psel & i_penable;    // zero wait states
  assign wr_en    = access & i_pwrite & addr_hit;
  assign o_pready = 1'b1;

  // ------------------------------
  // address decode and read mux
  // ------------------------------
  always_comb begin
    addr_hit = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      `REG_EXPL0:  o_prdata = {15'd0, cfg.expl0_en, 4'd0, cfg.expl0_row, 3'd0, cfg.expl0_col};
      `REG_EXPL1:  o_prdata = {15'd0, cfg.expl1_en, 4'd0, cfg.expl1_row, 3'd0, cfg.expl1_col};
      `REG_BG:     o_prdata = {20'd0, cfg.bg_rgb};
      `REG_BORDER: o_prdata = {20'd0, cfg.border_rgb};
      default:     addr_hit = 1'b0;
    endcase
  end

  assign o_pslverr = access & ~addr_hit;  // reads and writes alike

  // ------------------------------
  // register write
  // ------------------------------
  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cfg.expl0_en   <= 1'b0;
      cfg.expl0_row  <= '0;
      cfg.expl0_col  <= '0;
      cfg.expl1_en   <= 1'b0;
      cfg.expl1_row  <= '0;
      cfg.expl1_col  <= '0;
      cfg.bg_rgb     <= `BG_RESET;
      cfg.border_rgb <= `BORDER_RESET;
    end else if (wr_en) begin
      case (i_paddr)
        `REG_EXPL0: begin
          cfg.expl0_en  <= i_pwdata[16];
          cfg.expl0_row <= i_pwdata[11:8];
          cfg.expl0_col <= i_pwdata[4:0];
        end
        `REG_EXPL1: begin
          cfg.expl1_en  <= i_pwdata[16];
          cfg.expl1_row <= i_pwdata[11:8];
          cfg.expl1_col <= i_pwdata[4:0];
        end
        `REG_BG:     cfg.bg_rgb     <= i_pwdata[11:0];
        `REG_BORDER: cfg.border_rgb <= i_pwdata[11:0];
        default: ;                        // blocked by addr_hit
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/pixel_if.sv */
`default_nettype none

// pixel stage, one cycle behind the draw position
interface pixel_if
  import render_pkg::*;
();

  logic out_of_map;
  row_t row;
  col_t col;

  modport source (
    output out_of_map, row, col
  );

  modport sink (
    input out_of_map, row, col
  );

endinterface

`default_nettype wire

/* verilog/cfg_if.sv */
`default_nettype none

// register values from the apb block to the colour stage
interface cfg_if
  import render_pkg::*;
();

  logic expl0_en;
  row_t expl0_row;
  col_t expl0_col;

  logic expl1_en;
  row_t expl1_row;
  col_t expl1_col;

  rgb_t bg_rgb;
  rgb_t border_rgb;

  modport source (
    output expl0_en, expl0_row, expl0_col,
    output expl1_en, expl1_row, expl1_col,
    output bg_rgb, border_rgb
  );

  modport sink (
    input expl0_en, expl0_row, expl0_col,
    input expl1_en, expl1_row, expl1_col,
    input bg_rgb, border_rgb
  );

endinterface

`default_nettype wire

/* verilog/render_pkg.sv */
`default_nettype none

`include "render_config.svh"

package render_pkg;

  typedef logic [11:0] rgb_t;      // r in 11:8, g in 7:4, b in 3:0
  typedef logic [10:0] xcoord_t;
  typedef logic [9:0]  ycoord_t;

  typedef logic [`MAP_ADDR_W-1:0] map_addr_t;

  typedef logic [4:0] col_t;       // 0..18
  typedef logic [3:0] row_t;       // 0..10

  // contents of one map cell as stored in the map memory
  typedef enum logic [1:0] {
    NO_BLK   = 2'd0,
    PERM_BLK = 2'd1,
    DEST_BLK = 2'd2,
    BOMB     = 2'd3
  } tile_state_e;

endpackage

`default_nettype wire

/* verilog/render_config.svh */
`ifndef RENDER_CONFIG_SVH
`define RENDER_CONFIG_SVH

// ------------------------------
// screen and border geometry
// ------------------------------
`define SCREEN_W      1280
`define SCREEN_H      800
`define BORDER_SIDE   32    // left and right
`define BORDER_TOP    96
`define BORDER_BOT    0

// ------------------------------
// map grid
// ------------------------------
`define NUM_COL       19
`define NUM_ROW       11
`define BLK_LOG2      6     // 64x64 pixel tiles
`define MAP_ADDR_W    8     // 19*11 = 209 tiles

// ------------------------------
// apb register map
// ------------------------------
`define REG_EXPL0     4'h0
`define REG_EXPL1     4'h4
`define REG_BG        4'h8
`define REG_BORDER    4'hC

// fixed tile colours, 4 bits per channel
`define COLOR_PERM    12'h888
`define COLOR_DEST    12'hA52
`define COLOR_BOMB    12'h222
`define COLOR_EXPL    12'hF80

`define BG_RESET      12'h173
`define BORDER_RESET  12'h000

`endif
